/* bench/frv_retire_properties.sv */
// Protocol checks on the retire stage bound into the top level
// Assumes the driver holds s4 steady while s4_valid is high
`timescale 1ns/1ps
`include "frv_cfg.svh"

module frv_retire_props (
    input logic                 g_clk,
    input logic                 g_resetn,
    input logic                 s4_valid,
    input logic                 s4_busy,
    input logic                 cf_req,
    input logic [`FRV_XLEN-1:0] cf_target,
    input logic                 cf_ack,
    input logic                 gpr_wen,    // Register file write strobe
    input logic                 progress,
    input logic [`FRV_XLEN-1:0] csr_mtvec,  // Trap vector base
    input logic [`FRV_XLEN-1:0] csr_mepc
);

    // Unacked request stays up with the same target
    a_cf_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> !s4_valid || (cf_req && $stable(cf_target)))
        else $error("cf_req or cf_target changed before cf_ack arrived");

    // Writes retire only with progress and never with a control-flow request
    a_wen_progress: assert property (@(posedge g_clk) disable iff (!g_resetn)
        gpr_wen |-> progress && !cf_req)
        else $error("GPR write enable raised without progress or during control flow");

    // Idle stage and cleared trap CSRs right out of reset
    a_reset_idle: assert property (@(posedge g_clk)
        $rose(g_resetn) && !s4_valid |-> !s4_busy && !cf_req &&
            csr_mtvec == '0 && csr_mepc == '0)
        else $error("busy, cf_req or trap CSRs not clear after reset");

endmodule

bind frv_retire frv_retire_props u_props (
    .g_clk     (g_clk),
    .g_resetn  (g_resetn),
    .s4_valid  (s4_valid),
    .s4_busy   (s4_busy),
    .cf_req    (cf_req),
    .cf_target (cf_target),
    .cf_ack    (cf_ack),
    .gpr_wen   (gpr_wr.wen),
    .progress  (progress),
    .csr_mtvec (csr_mtvec),
    .csr_mepc  (csr_mepc)
);

/* bench/frv_retire_tb.sv */
// Directed testbench for the retire subsystem
// Inputs change on the falling edge; cf_ack follows after 0 to 4 cycles
// CSR contents are read back through CSRRS with a zero mask into a GPR
`timescale 1ns/1ps
`include "frv_cfg.svh"

module frv_retire_tb;

    localparam int TIMEOUT_CYCLES = 2000;     // About ten times the test length

    logic                 g_clk;
    logic                 g_resetn;
    frv_pkg::s4_bundle_t  s4;
    logic                 s4_valid;
    logic                 s4_busy;
    logic                 cf_req;
    logic [`FRV_XLEN-1:0] cf_target;
    logic                 cf_ack;
    frv_pkg::trap_info_t  trap;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [`FRV_XLEN-1:0] rs1_rdata;
    logic [`FRV_XLEN-1:0] rs2_rdata;

    int                   errors;
    int                   cycles = 0;
    frv_pkg::trap_info_t  seen_trap;          // Trap output in the retire cycle
    logic [`FRV_XLEN-1:0] m_mtvec;            // Expected mtvec
    logic [`FRV_XLEN-1:0] m_mepc;             // Expected mepc after EBREAK

    tb_clock_gen u_clk (.g_clk(g_clk));

    frv_retire frv_retire_inst (.*);

    // Run limit ------------------------------------------------
    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // Compare tasks --------------------------------------------
    task automatic check_word(input logic [`FRV_XLEN-1:0] got,
                              input logic [`FRV_XLEN-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bool(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_trap(input frv_pkg::trap_info_t got,
                              input frv_pkg::trap_info_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got cpu %b intr %b cause %0d mtval %h pc %h, expected %h",
                     $time, what, got.cpu, got.intr, got.cause, got.mtval, got.pc, exp);
        end
    endtask

    // Stimulus helpers -----------------------------------------
    function automatic frv_pkg::s4_bundle_t make_instr(input int unit, input frv_pkg::uop_t op,
        input logic [4:0] rd, input logic [`FRV_XLEN-1:0] a, input logic [`FRV_XLEN-1:0] b,
        input logic [31:0] pc);
        frv_pkg::s4_bundle_t i;
        i       = '0;
        i.rd    = rd;
        i.opr_a = a;
        i.opr_b = b;
        i.pc    = pc;
        i.uop   = op;
        i.fu    = 5'(1 << unit);              // One-hot unit select
        i.size  = 2'b11;                      // Full-width encoding
        return i;
    endfunction

    function automatic frv_pkg::trap_info_t make_trap(input logic cpu, input logic intr,
        input logic [5:0] cause, input logic [`FRV_XLEN-1:0] mtval, input logic [31:0] pc);
        frv_pkg::trap_info_t t;
        t.cpu   = cpu;
        t.intr  = intr;
        t.cause = cause;
        t.mtval = mtval;
        t.pc    = pc;
        return t;
    endfunction

    // Present one instruction and hold it until it retires
    task automatic retire_op(input frv_pkg::s4_bundle_t b, input logic [`FRV_XLEN-1:0] target);
        int   delay;
        int   waited;
        logic is_cf;
        is_cf  = b.trap || b.fu[`FRV_FU_CFU];
        delay  = is_cf ? int'($urandom_range(4, 0)) : 0;
        waited = 0;
        @(negedge g_clk);
        s4       = b;
        s4_valid = 1'b1;
        cf_ack   = is_cf && (delay == 0);
        #1;
        while (s4_busy) begin                 // Stalled for the ack
            check_bool(cf_req, 1'b1, "cf_req while stalled");
            check_word(cf_target, target, "cf_target while stalled");
            @(negedge g_clk);
            waited++;
            cf_ack = (waited >= delay);
            #1;
        end
        check_bool(cf_req, is_cf, "cf_req in retire cycle");
        check_bool(waited == delay, 1'b1, "busy released in the ack cycle");
        if (is_cf) begin
            check_word(cf_target, target, "cf_target in retire cycle");
        end
        seen_trap = trap;
        @(negedge g_clk);
        s4_valid = 1'b0;
        cf_ack   = 1'b0;
    endtask

    // Both read ports look at the same register
    task automatic gpr_expect(input logic [4:0] idx, input logic [`FRV_XLEN-1:0] exp,
                              input string what);
        rs1 = idx;
        rs2 = idx;
        #1;
        check_word(rs1_rdata, exp, what);
        check_word(rs2_rdata, exp, {what, " on rs2"});
    endtask

    task automatic csr_access(input frv_pkg::uop_t op, input logic [11:0] addr,
                              input logic [`FRV_XLEN-1:0] wdata, input logic [4:0] rd);
        retire_op(make_instr(`FRV_FU_CSR, op, rd, wdata,
                             {{(`FRV_XLEN-12){1'b0}}, addr}, 32'h0000_0800), '0);
    endtask

    task automatic csr_expect(input logic [11:0] addr, input logic [`FRV_XLEN-1:0] exp,
                              input string what);
        csr_access(frv_pkg::CSR_RS, addr, '0, 5'd31); // Zero mask leaves the CSR as is
        gpr_expect(5'd31, exp, what);
    endtask

    // Tests ----------------------------------------------------
    task automatic test_writeback();
        logic [4:0]           rd;
        logic [`FRV_XLEN-1:0] val;
        for (int i = 0; i < 8; i++) begin
            rd  = 5'($urandom_range(31, 1));
            val = $urandom;
            // ALU, MUL, LSU in turn
            retire_op(make_instr(i % 3, frv_pkg::UOP_NONE, rd, val, '0, 32'h100 + 4 * i), '0);
            gpr_expect(rd, val, "writeback read back");
        end
        retire_op(make_instr(`FRV_FU_ALU, frv_pkg::UOP_NONE, 5'd0, 32'hdead_beef, '0,
                             32'h0000_0200), '0);
        gpr_expect(5'd0, '0, "x0 after write");
    endtask

    task automatic test_jump();
        logic [`FRV_XLEN-1:0] keep;
        logic [`FRV_XLEN-1:0] tgt;
        keep = $urandom;
        tgt  = $urandom & 32'hffff_fffe;
        retire_op(make_instr(`FRV_FU_ALU, frv_pkg::UOP_NONE, 5'd5, keep, '0, 32'h300), '0);
        retire_op(make_instr(`FRV_FU_CFU, frv_pkg::CFU_TAKEN, 5'd5, tgt, '0, 32'h304), tgt);
        gpr_expect(5'd5, keep, "GPR after taken jump");
    endtask

    task automatic test_csr();
        logic [`FRV_XLEN-1:0] scratch;
        logic [`FRV_XLEN-1:0] mask;
        scratch = $urandom;
        csr_access(frv_pkg::CSR_RW, `FRV_CSR_MSCRATCH, scratch, 5'd6);
        gpr_expect(5'd6, '0, "old mscratch");
        m_mtvec = $urandom & 32'hffff_fffc;  // Aligned base for direct mode
        csr_access(frv_pkg::CSR_RW, `FRV_CSR_MTVEC, m_mtvec, 5'd7);
        gpr_expect(5'd7, '0, "old mtvec");
        csr_expect(`FRV_CSR_MTVEC, m_mtvec, "mtvec after CSRRW");
        mask = $urandom;
        csr_access(frv_pkg::CSR_RS, `FRV_CSR_MSCRATCH, mask, 5'd8);
        gpr_expect(5'd8, scratch, "mscratch before CSRRS");
        scratch = scratch | mask;
        mask    = $urandom;
        csr_access(frv_pkg::CSR_RC, `FRV_CSR_MSCRATCH, mask, 5'd9);
        gpr_expect(5'd9, scratch, "mscratch before CSRRC");
        scratch = scratch & ~mask;
        csr_expect(`FRV_CSR_MSCRATCH, scratch, "mscratch after set and clear");
        csr_access(frv_pkg::CSR_RW, 12'h7c0, 32'h1234_5678, 5'd10);
        gpr_expect(5'd10, '0, "unknown CSR read");
        csr_expect(12'h7c0, '0, "unknown CSR after write");
    endtask

    task automatic test_ecall_ebreak();
        logic [31:0] pc;
        pc = $urandom & 32'hffff_fffc;
        retire_op(make_instr(`FRV_FU_CFU, frv_pkg::CFU_ECALL, 5'd0, '0, '0, pc), m_mtvec);
        check_trap(seen_trap, make_trap(1'b1, 1'b0, 6'd11, '0, pc), "ECALL trap record");
        csr_expect(`FRV_CSR_MEPC, pc, "mepc after ECALL");
        csr_expect(`FRV_CSR_MCAUSE, 32'd11, "mcause after ECALL");
        csr_expect(`FRV_CSR_MTVAL, '0, "mtval after ECALL");
        m_mepc = $urandom & 32'hffff_fffc;
        retire_op(make_instr(`FRV_FU_CFU, frv_pkg::CFU_EBREAK, 5'd0, '0, '0, m_mepc), m_mtvec);
        check_trap(seen_trap, make_trap(1'b1, 1'b0, 6'd3, m_mepc, m_mepc), "EBREAK trap record");
        csr_expect(`FRV_CSR_MEPC, m_mepc, "mepc after EBREAK");
        csr_expect(`FRV_CSR_MCAUSE, 32'd3, "mcause after EBREAK");
        csr_expect(`FRV_CSR_MTVAL, m_mepc, "mtval after EBREAK");
    endtask

    task automatic test_mret();
        retire_op(make_instr(`FRV_FU_CFU, frv_pkg::CFU_MRET, 5'd0, '0, '0, 32'h400), m_mepc);
        check_trap(seen_trap, make_trap(1'b0, 1'b0, 6'd0, '0, 32'h400), "MRET trap record");
    endtask

    task automatic test_interrupt();
        frv_pkg::s4_bundle_t  b;
        logic [`FRV_XLEN-1:0] keep;
        keep = $urandom;
        retire_op(make_instr(`FRV_FU_ALU, frv_pkg::UOP_NONE, 5'd12, keep, '0, 32'h500), '0);
        b      = make_instr(`FRV_FU_ALU, frv_pkg::UOP_NONE, 5'd12, ~keep, '0, 32'h504);
        b.trap = 1'b1;                         // Interrupt displaces the ALU op
        retire_op(b, m_mtvec);
        check_trap(seen_trap, make_trap(1'b0, 1'b1, 6'd11, '0, 32'h504), "interrupt record");
        gpr_expect(5'd12, keep, "GPR after interrupt");
        csr_expect(`FRV_CSR_MCAUSE, 32'h8000_000b, "mcause after interrupt");
        csr_expect(`FRV_CSR_MEPC, 32'h504, "mepc after interrupt");
    endtask

    // Main sequence --------------------------------------------
    initial begin
        void'($urandom(61));
        errors   = 0;
        g_resetn = 1'b0;
        s4       = '0;
        s4_valid = 1'b0;
        cf_ack   = 1'b0;
        rs1      = 5'd0;
        rs2      = 5'd0;
        repeat (3) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        test_writeback();
        test_jump();
        test_csr();
        test_ecall_ebreak();
        test_mret();
        test_interrupt();
        $display("Run complete: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* bench/tb_clock_gen.sv */
// Free-running bench clock, 100 ns period, starts low
`timescale 1ns/1ps

module tb_clock_gen (
    output logic g_clk
);

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;      // Half of 100 ns
    end

endmodule

/* frv_retire.f */
+incdir+verilog
verilog/frv_pkg.sv
verilog/frv_pipeline_writeback.sv
verilog/frv_gprs.sv
verilog/frv_csrs.sv
verilog/frv_retire.sv
bench/tb_clock_gen.sv
bench/frv_retire_properties.sv
bench/frv_retire_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and return success only if the bench reports a clean run
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module frv_retire_tb \
    -f frv_retire.f -o frv_retire_sim || exit 1
./obj_dir/frv_retire_sim | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
    && exit 0 || exit 1

/* verilog/frv_cfg.svh */
// Core configuration for the retire subsystem
// XLEN other than 32 is untested; mcause layout assumes XLEN > 7
// Functional-unit positions index the one-hot fu field of the s4 bundle
`ifndef FRV_CFG_SVH
`define FRV_CFG_SVH

`define FRV_XLEN          32          // Data path width
`define FRV_NREGS         32          // Number of GPRs, x0 included

// Functional unit bit positions ------------------------------
`define FRV_FU_ALU        0
`define FRV_FU_MUL        1
`define FRV_FU_LSU        2
`define FRV_FU_CFU        3
`define FRV_FU_CSR        4

// Trap cause codes, 6 bits wide
`define FRV_CAUSE_ECALL   6'd11       // Environment call from M-mode
`define FRV_CAUSE_EBREAK  6'd3        // Breakpoint
`define FRV_CAUSE_MEXT    6'd11       // Machine external interrupt

// Machine-mode CSR addresses ---------------------------------
`define FRV_CSR_MTVEC     12'h305
`define FRV_CSR_MSCRATCH  12'h340
`define FRV_CSR_MEPC      12'h341
`define FRV_CSR_MCAUSE    12'h342
`define FRV_CSR_MTVAL     12'h343

`endif

/* verilog/frv_csrs.sv */
// Minimal machine-mode CSR file: mtvec, mepc, mcause, mtval, mscratch
// Reads are combinational, updates land on the progress edge
// Unknown addresses read zero and drop writes; no counters or interrupt enables
`timescale 1ns/1ps
`include "frv_cfg.svh"

module frv_csrs (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  frv_pkg::csr_access_t  acc,
    input  frv_pkg::trap_info_t   trap,
    input  logic                  progress,  // Stage retires this cycle
    output logic [`FRV_XLEN-1:0]  rdata,     // Old value of addressed CSR
    output logic [`FRV_XLEN-1:0]  mtvec,
    output logic [`FRV_XLEN-1:0]  mepc
);

    logic [`FRV_XLEN-1:0] mcause;
    logic [`FRV_XLEN-1:0] mtval;
    logic [`FRV_XLEN-1:0] mscratch;
    logic [`FRV_XLEN-1:0] wval;       // Value after read-modify-write
    logic sel_mtvec, sel_mepc, sel_mcause, sel_mtval, sel_mscratch;
    logic wr_en;
    logic take_trap;

    // Address decode ---------------------------------------------
    assign sel_mtvec    = (acc.addr == `FRV_CSR_MTVEC);
    assign sel_mepc     = (acc.addr == `FRV_CSR_MEPC);
    assign sel_mcause   = (acc.addr == `FRV_CSR_MCAUSE);
    assign sel_mtval    = (acc.addr == `FRV_CSR_MTVAL);
    assign sel_mscratch = (acc.addr == `FRV_CSR_MSCRATCH);

    always_comb begin
        rdata = '0;                   // Unknown CSR reads zero
        if (sel_mtvec)    rdata = mtvec;
        if (sel_mepc)     rdata = mepc;
        if (sel_mcause)   rdata = mcause;
        if (sel_mtval)    rdata = mtval;
        if (sel_mscratch) rdata = mscratch;
    end

    // New value from the old one
    always_comb begin
        case (acc.op)
            frv_pkg::CSR_RW: wval = acc.wdata;
            frv_pkg::CSR_RS: wval = rdata | acc.wdata;
            frv_pkg::CSR_RC: wval = rdata & ~acc.wdata;
            default:         wval = rdata;
        endcase
    end

    assign wr_en     = acc.en && progress;
    assign take_trap = progress && (trap.cpu || trap.intr);

    // Register update --------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mscratch <= '0;
        end else if (take_trap) begin
            mepc   <= trap.pc;
            mcause <= {trap.intr, {(`FRV_XLEN-7){1'b0}}, trap.cause}; // Flag in MSB
            mtval  <= trap.mtval;
        end else if (wr_en) begin
            if (sel_mtvec)    mtvec    <= wval;
            if (sel_mepc)     mepc     <= wval;
            if (sel_mcause)   mcause   <= wval;
            if (sel_mtval)    mtval    <= wval;
            if (sel_mscratch) mscratch <= wval;
        end
    end

endmodule

/* verilog/frv_gprs.sv */
// General purpose register file, one write and two read ports
// Reads are combinational; a write shows on the read port the next cycle
// x0 ignores writes and always reads zero
`timescale 1ns/1ps
`include "frv_cfg.svh"

module frv_gprs (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  frv_pkg::gpr_write_t   wr,
    input  logic [4:0]            rs1,
    input  logic [4:0]            rs2,
    output logic [`FRV_XLEN-1:0]  rs1_rdata,
    output logic [`FRV_XLEN-1:0]  rs2_rdata
);

    logic [`FRV_XLEN-1:0] regs [`FRV_NREGS];

    // Write port -------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `FRV_NREGS; i++) begin
                regs[i] <= '0;            // Whole file starts at zero
            end
        end else if (wr.wen && (wr.rd != 5'd0)) begin
            regs[wr.rd] <= wr.wdata;
        end
    end

    // Read ports -------------------------------------------------
    assign rs1_rdata = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_rdata = (rs2 == 5'd0) ? '0 : regs[rs2]; // For a later decode stage

endmodule

/* verilog/frv_pipeline_writeback.sv */
// Final pipeline stage for GPR writeback, CSR access, traps and control flow
// Control-flow ops stall until cf_ack; inputs must hold while s4_valid is high
// An interrupt displaces the presented instruction without GPR or CSR write
`timescale 1ns/1ps
`include "frv_cfg.svh"

module frv_pipeline_writeback (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  frv_pkg::s4_bundle_t   s4,        // Retiring instruction
    input  logic                  s4_valid,
    output logic                  s4_busy,
    output frv_pkg::gpr_write_t   gpr_wr,
    output frv_pkg::csr_access_t  csr_acc,
    input  logic [`FRV_XLEN-1:0]  csr_rdata, // Old value of addressed CSR
    input  logic [`FRV_XLEN-1:0]  csr_mtvec,
    input  logic [`FRV_XLEN-1:0]  csr_mepc,
    output frv_pkg::trap_info_t   trap,
    output logic                  cf_req,
    output logic [`FRV_XLEN-1:0]  cf_target,
    input  logic                  cf_ack
);

    logic fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic cfu_taken, cfu_ecall, cfu_ebreak, cfu_mret, cfu_trap;
    logic cf_op;            // Any control-flow change this instruction
    logic finish_now;       // Request acknowledged this cycle
    logic progress;
    logic retire_ok;        // Instruction not displaced by interrupt

    // Operation decode -------------------------------------------
    assign fu_alu = s4.fu[`FRV_FU_ALU];
    assign fu_mul = s4.fu[`FRV_FU_MUL];
    assign fu_lsu = s4.fu[`FRV_FU_LSU];
    assign fu_cfu = s4.fu[`FRV_FU_CFU];
    assign fu_csr = s4.fu[`FRV_FU_CSR];

    assign cfu_taken  = fu_cfu && (s4.uop == frv_pkg::CFU_TAKEN);
    assign cfu_ecall  = fu_cfu && (s4.uop == frv_pkg::CFU_ECALL);
    assign cfu_ebreak = fu_cfu && (s4.uop == frv_pkg::CFU_EBREAK);
    assign cfu_mret   = fu_cfu && (s4.uop == frv_pkg::CFU_MRET);
    assign cfu_trap   = cfu_ecall || cfu_ebreak;

    assign retire_ok  = !s4.trap;

    // Control-flow handshake -------------------------------------
    assign cf_op      = cfu_taken || cfu_trap || cfu_mret || s4.trap;
    assign cf_req     = s4_valid && cf_op;
    assign finish_now = cf_req && cf_ack;
    assign s4_busy    = cf_req && !finish_now;      // Stall until acked
    assign progress   = s4_valid && !s4_busy;

    always_comb begin
        if (s4.trap || cfu_trap) begin
            cf_target = csr_mtvec;        // Direct mode only
        end else if (cfu_mret) begin
            cf_target = csr_mepc;
        end else if (cfu_taken) begin
            cf_target = s4.opr_a;         // Target computed upstream
        end else begin
            cf_target = '0;
        end
    end

    // GPR writeback ----------------------------------------------
    always_comb begin
        gpr_wr.wen   = progress && retire_ok && (s4.rd != 5'd0) &&
                       (fu_alu || fu_mul || fu_lsu || fu_csr);
        gpr_wr.rd    = s4.rd;
        gpr_wr.wdata = fu_csr ? csr_rdata : s4.opr_a; // CSR returns old value
    end

    // CSR access committed by the CSR file on progress
    always_comb begin
        csr_acc.en    = s4_valid && retire_ok && fu_csr;
        csr_acc.addr  = s4.opr_b[11:0];
        csr_acc.op    = s4.uop;
        csr_acc.wdata = s4.opr_a;
    end

    // Trap record ------------------------------------------------
    always_comb begin
        trap.cpu  = cfu_trap;
        trap.intr = s4.trap;
        if (s4.trap) begin
            trap.cause = `FRV_CAUSE_MEXT;   // Interrupt wins over exception
        end else if (cfu_ecall) begin
            trap.cause = `FRV_CAUSE_ECALL;
        end else if (cfu_ebreak) begin
            trap.cause = `FRV_CAUSE_EBREAK;
        end else begin
            trap.cause = 6'd0;
        end
        trap.mtval = (cfu_ebreak && !s4.trap) ? s4.pc : '0; // Zero for ECALL
        trap.pc    = s4.pc;
    end

endmodule

/* verilog/frv_pkg.sv */
// Shared types for the retire stage, GPRs, CSRs and bench
// Widths follow the configuration header; uop codes are local to this design
`include "frv_cfg.svh"

package frv_pkg;

    // Micro-ops seen at retire --------------------------------
    typedef enum logic [4:0] {
        UOP_NONE   = 5'd0,            // ALU, MUL and LSU results
        CFU_TAKEN  = 5'd1,            // Taken branch or jump
        CFU_ECALL  = 5'd2,
        CFU_EBREAK = 5'd3,
        CFU_MRET   = 5'd4,
        CSR_RW     = 5'd5,
        CSR_RS     = 5'd6,
        CSR_RC     = 5'd7
    } uop_t;

    // Retiring instruction
    typedef struct packed {
        logic [4:0]           rd;     // Destination GPR
        logic [`FRV_XLEN-1:0] opr_a;  // Result, jump target or CSR source
        logic [`FRV_XLEN-1:0] opr_b;  // Low 12 bits hold CSR address
        logic [31:0]          pc;
        uop_t                 uop;
        logic [4:0]           fu;     // One-hot unit select
        logic                 trap;   // Pending interrupt
        logic [1:0]           size;   // Instruction size
        logic [31:0]          instr;  // Raw encoding
    } s4_bundle_t;

    // GPR write port
    typedef struct packed {
        logic                 wen;
        logic [4:0]           rd;
        logic [`FRV_XLEN-1:0] wdata;
    } gpr_write_t;

    // CSR read-modify-write request
    typedef struct packed {
        logic                 en;
        logic [11:0]          addr;
        uop_t                 op;     // CSR_RW, CSR_RS or CSR_RC
        logic [`FRV_XLEN-1:0] wdata;
    } csr_access_t;

    // Trap record handed to the CSR file
    typedef struct packed {
        logic                 cpu;    // Synchronous exception
        logic                 intr;   // Interrupt
        logic [5:0]           cause;
        logic [`FRV_XLEN-1:0] mtval;
        logic [`FRV_XLEN-1:0] pc;
    } trap_info_t;

endpackage

/* verilog/frv_retire.sv */
// Retire subsystem top: writeback stage, GPR file and CSR file
// GPR read ports are exposed for observation and a later decode stage
// cf_ack must answer every cf_req or the stage stalls indefinitely
`timescale 1ns/1ps
`include "frv_cfg.svh"

module frv_retire (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  frv_pkg::s4_bundle_t   s4,
    input  logic                  s4_valid,
    output logic                  s4_busy,
    output logic                  cf_req,
    output logic [`FRV_XLEN-1:0]  cf_target,
    input  logic                  cf_ack,
    output frv_pkg::trap_info_t   trap,
    input  logic [4:0]            rs1,
    output logic [`FRV_XLEN-1:0]  rs1_rdata,
    input  logic [4:0]            rs2,
    output logic [`FRV_XLEN-1:0]  rs2_rdata
);

    frv_pkg::gpr_write_t  gpr_wr;
    frv_pkg::csr_access_t csr_acc;
    logic [`FRV_XLEN-1:0] csr_rdata;
    logic [`FRV_XLEN-1:0] csr_mtvec;
    logic [`FRV_XLEN-1:0] csr_mepc;
    logic                 progress;

    assign progress = s4_valid && !s4_busy;   // Instruction retires

    // Stage ------------------------------------------------------
    frv_pipeline_writeback u_wb (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .s4        (s4),
        .s4_valid  (s4_valid),
        .s4_busy   (s4_busy),
        .gpr_wr    (gpr_wr),
        .csr_acc   (csr_acc),
        .csr_rdata (csr_rdata),
        .csr_mtvec (csr_mtvec),
        .csr_mepc  (csr_mepc),
        .trap      (trap),
        .cf_req    (cf_req),
        .cf_target (cf_target),
        .cf_ack    (cf_ack)
    );

    frv_gprs u_gprs (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .wr        (gpr_wr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata)
    );

    frv_csrs u_csrs (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .acc       (csr_acc),
        .trap      (trap),
        .progress  (progress),
        .rdata     (csr_rdata),
        .mtvec     (csr_mtvec),
        .mepc      (csr_mepc)
    );

endmodule
